//--- verilog.f
+incdir+.
gat_dbg_pkg.sv
stage_event_monitor.sv
capture_fifo.sv
dbg_axil_regs.sv
gat_debug_top.sv
tb_clk_gen.sv
tb_gat_debug.sv

//--- Bender.yml
package:
  name: gat_debug

export_include_dirs:
  - .

sources:
  - gat_dbg_pkg.sv
  - stage_event_monitor.sv
  - capture_fifo.sv
  - dbg_axil_regs.sv
  - gat_debug_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_gat_debug.sv

//--- tb_gat_debug.sv
`timescale 1ns/100ps
`default_nettype none

`include "gat_dbg_defines.svh"

module tb_gat_debug;

  localparam int MAX_CYCLES = 4000;
  localparam logic [`GAT_WH_ADDR_W-1:0] IDLE_ADDR = '1;
  localparam logic [1:0] OKAY   = `GAT_AXI_RESP_OKAY;
  localparam logic [1:0] SLVERR = `GAT_AXI_RESP_SLVERR;

  logic                                        clk;
  logic                                        rst_n;
  gat_dbg_pkg::axil_req_t                      axil_req;
  gat_dbg_pkg::axil_rsp_t                      axil_rsp;
  gat_dbg_pkg::stage_bus_t                     stages;
  logic [`GAT_WH_ADDR_W-1:0]                   wh_addr;
  logic [`GAT_SPPE_LANES-1:0][`GAT_SPPE_W-1:0] sppe;
  gat_dbg_pkg::feat_wr_t                       feat_wr;

  // expected monitor state from the register map rules.
  gat_dbg_pkg::sticky_t                        sticky_model;
  logic [31:0]                                 sm_model;
  logic [`GAT_CAP_SEQ_W-1:0]                   seq_model;
  gat_dbg_pkg::capture_rec_t                   cap_model[$];
  logic [`GAT_WH_ADDR_W-1:0]                   watch0_val;
  logic [`GAT_WH_ADDR_W-1:0]                   watch1_val;
  int                                          cycle_cnt;

  tb_clk_gen u_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_debug_top u_gat_debug_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .axil_req_i (axil_req),
    .stages_i   (stages),
    .wh_addr_i  (wh_addr),
    .sppe_i     (sppe),
    .feat_wr_i  (feat_wr),
    .axil_rsp_o (axil_rsp)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      stop_on_error($sformatf("timeout: the tests did not finish within %0d cycles",
                              MAX_CYCLES));
    end
  end

  task automatic check_word(input string name, input logic [31:0] act,
                            input logic [31:0] exp);
    if (act !== exp) begin
      stop_on_error($sformatf("ERROR t=%0t %s: got 0x%08h, expected 0x%08h",
                              $time, name, act, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] act,
                            input logic [1:0] exp);
    if (act !== exp) begin
      stop_on_error($sformatf("ERROR t=%0t %s: got %b, expected %b",
                              $time, name, act, exp));
    end
  endtask

  task automatic check_sticky(input gat_dbg_pkg::sticky_t act,
                              input gat_dbg_pkg::sticky_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("ERROR t=%0t sticky_o: got %b, expected %b",
                              $time, act, exp));
    end
  endtask

  task automatic check_capture(input gat_dbg_pkg::capture_rec_t act,
                               input gat_dbg_pkg::capture_rec_t exp);
    if (act !== exp) begin
      stop_on_error($sformatf("ERROR t=%0t cap_data: got 0x%08h, expected 0x%08h",
                              $time, act, exp));
    end
  endtask

  // outputs are sampled at the falling edge while they are stable.
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] bresp);
    logic accepted;
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = '1;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = axil_rsp.awready && axil_rsp.wready;
      @(posedge clk);
    end
    #10;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    @(negedge clk);
    while (!axil_rsp.bvalid) @(negedge clk);
    bresp = axil_rsp.bresp;
    @(posedge clk);
    #10;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] rresp);
    logic accepted;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = axil_rsp.arready;
      @(posedge clk);
    end
    #10;
    axil_req.arvalid = 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    data  = axil_rsp.rdata;
    rresp = axil_rsp.rresp;
    @(posedge clk);
    #10;
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr,
                             input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  rresp;
    axil_read(addr, data, rresp);
    check_resp({name, " rresp"}, rresp, OKAY);
    check_word(name, data, exp);
  endtask

  task automatic check_status();
    logic [31:0] data;
    logic [1:0]  rresp;
    axil_read(`REG_STATUS, data, rresp);
    check_resp("STATUS rresp", rresp, OKAY);
    check_word("STATUS upper bits", data & ~32'h7FF, 32'h0);
    check_sticky(gat_dbg_pkg::sticky_t'(data[10:0]), sticky_model);
  endtask

  task automatic clear_monitor();
    logic [1:0] bresp;
    axil_write(`REG_CTRL, 32'h1, bresp);
    check_resp("CTRL bresp", bresp, OKAY);
    sticky_model = '0;
    sm_model     = '0;
    seq_model    = '0;
  endtask

  task automatic pulse_stages(input gat_dbg_pkg::stage_bus_t s, input int cycles);
    stages = s;
    repeat (cycles) begin
      sticky_model.hs_seen = sticky_model.hs_seen | s;
      if (s.sm.vld) begin
        sm_model = sm_model + 32'd1;
      end
      @(posedge clk);
    end
    #10;
    stages = '0;
  endtask

  task automatic feature_write(input logic [`GAT_FEAT_ADDR_W-1:0] addr);
    feat_wr.ena  = 1'b1;
    feat_wr.addr = addr;
    sticky_model.feat_wr_seen = 1'b1;
    if (addr >= `GAT_FEAT_ADDR_LIMIT) begin
      sticky_model.feat_over_limit = 1'b1;
    end
    @(posedge clk);
    #10;
    feat_wr = '0;
  endtask

  // one weight-buffer access that also pushes the expected capture to the model.
  task automatic weight_access(input logic [`GAT_WH_ADDR_W-1:0] addr, input logic rdy);
    gat_dbg_pkg::capture_rec_t rec;
    logic [`GAT_SPPE_W-1:0]    lane_val;
    lane_val = `GAT_SPPE_W'($urandom);
    for (int i = 0; i < `GAT_SPPE_LANES; i++) begin
      sppe[i] = `GAT_SPPE_W'($urandom);
    end
    sppe[`GAT_SPPE_WATCH_LANE] = lane_val;
    wh_addr          = addr;
    stages.spmm.rdy  = rdy;
    if (rdy) begin
      sticky_model.hs_seen.spmm.rdy = 1'b1;
      if (addr == watch0_val || addr == watch1_val) begin
        rec.watch_hit = (addr != watch0_val);
        rec.addr      = addr;
        rec.lane      = lane_val;
        rec.seq       = seq_model;
        if (cap_model.size() < `GAT_CAP_DEPTH) begin
          cap_model.push_back(rec);
        end else begin
          sticky_model.cap_overflow = 1'b1;
        end
        seq_model = seq_model + 1'b1;
      end
    end
    @(posedge clk);
    #10;
    wh_addr = IDLE_ADDR;
    stages  = '0;
  endtask

  task automatic drain_captures();
    logic [31:0] data;
    logic [1:0]  rresp;
    read_expect("CAP_LEVEL", `REG_CAP_LEVEL, 32'(cap_model.size()));
    while (cap_model.size() > 0) begin
      axil_read(`REG_CAP_DATA, data, rresp);
      check_resp("CAP_DATA rresp", rresp, OKAY);
      check_capture(gat_dbg_pkg::capture_rec_t'(data), cap_model.pop_front());
    end
    axil_read(`REG_CAP_DATA, data, rresp);
    check_resp("CAP_DATA empty rresp", rresp, SLVERR);
    check_word("CAP_DATA empty", data, 32'h0);
  endtask

  task automatic test_reset_values();
    // awready, wready, arready high and bvalid, rvalid low out of reset.
    check_word("axil_rsp ready/valid",
               32'({axil_rsp.awready, axil_rsp.wready, axil_rsp.arready,
                    axil_rsp.bvalid, axil_rsp.rvalid}),
               32'b11100);
    read_expect("ID", `REG_ID, `GAT_DBG_ID);
    read_expect("NUM_SPARSE", `REG_NUM_SPARSE, 32'd12);
    read_expect("SM_COUNT", `REG_SM_COUNT, 32'h0);
    read_expect("CAP_LEVEL", `REG_CAP_LEVEL, 32'h0);
    read_expect("WATCH0", `REG_WATCH0, 32'h0);
    check_status();
  endtask

  task automatic test_stage_flags();
    int n;
    for (int i = 0; i < 8; i++) begin
      pulse_stages(gat_dbg_pkg::stage_bus_t'(8'b1 << i), 1);
      check_status();
    end
    n = 2 + ($urandom % 30);
    pulse_stages(gat_dbg_pkg::stage_bus_t'(8'b0000_1000), n);
    read_expect("SM_COUNT", `REG_SM_COUNT, sm_model);
    check_status();
  endtask

  task automatic test_feature_and_clear();
    clear_monitor();
    repeat (3) begin
      feature_write(`GAT_FEAT_ADDR_W'($urandom % `GAT_FEAT_ADDR_LIMIT));
    end
    check_status();
    feature_write(`GAT_FEAT_ADDR_W'(`GAT_FEAT_ADDR_LIMIT));
    check_status();
    pulse_stages(gat_dbg_pkg::stage_bus_t'(8'b0000_1000), 3);
    clear_monitor();
    check_status();
    read_expect("SM_COUNT", `REG_SM_COUNT, 32'h0);
  endtask

  task automatic test_capture();
    logic [1:0]                bresp;
    logic [`GAT_WH_ADDR_W-1:0] other;
    watch0_val = `GAT_WH_ADDR_W'($urandom % 16383);
    watch1_val = `GAT_WH_ADDR_W'((watch0_val + 1 + ($urandom % 100)) % 16383);
    other      = `GAT_WH_ADDR_W'((watch0_val + 200 + ($urandom % 100)) % 16383);
    axil_write(`REG_WATCH0, 32'(watch0_val), bresp);
    check_resp("WATCH0 bresp", bresp, OKAY);
    axil_write(`REG_WATCH1, 32'(watch1_val), bresp);
    check_resp("WATCH1 bresp", bresp, OKAY);
    read_expect("WATCH0", `REG_WATCH0, 32'(watch0_val));
    read_expect("WATCH1", `REG_WATCH1, 32'(watch1_val));
    weight_access(watch0_val, 1'b1);
    weight_access(other, 1'b1);
    weight_access(watch1_val, 1'b1);
    weight_access(watch0_val, 1'b0);
    weight_access(watch1_val, 1'b0);
    weight_access(watch1_val, 1'b1);
    weight_access(watch0_val, 1'b1);
    check_status();
    drain_captures();
  endtask

  task automatic test_fifo_overflow();
    clear_monitor();
    for (int i = 0; i < 10; i++) begin
      weight_access((i % 2 == 0) ? watch0_val : watch1_val, 1'b1);
    end
    check_status();
    drain_captures();
  endtask

  task automatic test_bus_errors();
    logic [31:0] data;
    logic [31:0] held;
    logic [1:0]  rresp;
    logic [1:0]  bresp;
    axil_write(`REG_ID, 32'hFFFF_FFFF, bresp);
    check_resp("ID write bresp", bresp, SLVERR);
    axil_write(8'h40, 32'h1, bresp);
    check_resp("unmapped write bresp", bresp, SLVERR);
    axil_read(8'h40, data, rresp);
    check_resp("unmapped read rresp", rresp, SLVERR);
    read_expect("ID after write", `REG_ID, `GAT_DBG_ID);
    // read of ID with rready held low for five cycles.
    axil_req.araddr  = `REG_ID;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b0;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    #10;
    axil_req.arvalid = 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    held = axil_rsp.rdata;
    check_resp("held rresp", axil_rsp.rresp, OKAY);
    repeat (5) begin
      @(negedge clk);
      check_word("held rvalid", 32'(axil_rsp.rvalid), 32'h1);
      check_word("held arready", 32'(axil_rsp.arready), 32'h0);
      check_word("held rdata", axil_rsp.rdata, held);
    end
    @(posedge clk);
    #10;
    axil_req.rready = 1'b1;
    @(negedge clk);
    @(negedge clk);
    check_word("rvalid after rready", 32'(axil_rsp.rvalid), 32'h0);
    check_word("held ID", held, `GAT_DBG_ID);
    @(posedge clk);
    #10;
  endtask

  initial begin
    void'($urandom(51493));
    cycle_cnt    = 0;
    axil_req     = '0;
    stages       = '0;
    wh_addr      = IDLE_ADDR;
    sppe         = '0;
    feat_wr      = '0;
    sticky_model = '0;
    sm_model     = '0;
    seq_model    = '0;
    watch0_val   = '0;
    watch1_val   = '0;
    @(posedge rst_n);
    @(posedge clk);
    #10;
    test_reset_values();
    test_stage_flags();
    test_feature_and_clear();
    test_capture();
    test_fifo_overflow();
    test_bus_errors();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release lands a little after the clock edge.
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- gat_debug_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "gat_dbg_defines.svh"

module gat_debug_top (
  input  wire logic                                        clk,
  input  wire logic                                        rst_n,
  input  wire gat_dbg_pkg::axil_req_t                      axil_req_i,
  input  wire gat_dbg_pkg::stage_bus_t                     stages_i,
  input  wire logic [`GAT_WH_ADDR_W-1:0]                   wh_addr_i,
  input  wire logic [`GAT_SPPE_LANES-1:0][`GAT_SPPE_W-1:0] sppe_i,
  input  wire gat_dbg_pkg::feat_wr_t                       feat_wr_i,
  output gat_dbg_pkg::axil_rsp_t                           axil_rsp_o
);

  gat_dbg_pkg::sticky_t          sticky;
  logic [31:0]                   sm_count;
  gat_dbg_pkg::capture_rec_t     cap_rec;
  logic                          cap_push;
  gat_dbg_pkg::capture_rec_t     cap_head;
  logic                          cap_full;
  logic                          cap_empty;
  logic [`GAT_CAP_LEVEL_W-1:0]   cap_level;
  logic                          cap_pop;
  logic [`GAT_WH_ADDR_W-1:0]     watch0;
  logic [`GAT_WH_ADDR_W-1:0]     watch1;
  logic                          clear;

  stage_event_monitor u_stage_event_monitor (
    .clk        (clk),
    .rst_n      (rst_n),
    .stages_i   (stages_i),
    .wh_addr_i  (wh_addr_i),
    .sppe_i     (sppe_i),
    .feat_wr_i  (feat_wr_i),
    .watch0_i   (watch0),
    .watch1_i   (watch1),
    .clear_i    (clear),
    .cap_full_i (cap_full),
    .sticky_o   (sticky),
    .sm_count_o (sm_count),
    .cap_rec_o  (cap_rec),
    .cap_push_o (cap_push)
  );

  capture_fifo #(
    .payload_t (gat_dbg_pkg::capture_rec_t)
  ) u_capture_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (cap_push),
    .push_data_i (cap_rec),
    .pop_i       (cap_pop),
    .pop_data_o  (cap_head),
    .full_o      (cap_full),
    .empty_o     (cap_empty),
    .level_o     (cap_level)
  );

  dbg_axil_regs u_dbg_axil_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .axil_req_i  (axil_req_i),
    .sticky_i    (sticky),
    .sm_count_i  (sm_count),
    .cap_data_i  (cap_head),
    .cap_empty_i (cap_empty),
    .cap_level_i (cap_level),
    .axil_rsp_o  (axil_rsp_o),
    .watch0_o    (watch0),
    .watch1_o    (watch1),
    .clear_o     (clear),
    .cap_pop_o   (cap_pop)
  );

endmodule

`default_nettype wire

//--- dbg_axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "gat_dbg_defines.svh"

module dbg_axil_regs (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire gat_dbg_pkg::axil_req_t        axil_req_i,
  input  wire gat_dbg_pkg::sticky_t          sticky_i,
  input  wire logic [31:0]                   sm_count_i,
  input  wire gat_dbg_pkg::capture_rec_t     cap_data_i,
  input  wire logic                          cap_empty_i,
  input  wire logic [`GAT_CAP_LEVEL_W-1:0]   cap_level_i,
  output gat_dbg_pkg::axil_rsp_t             axil_rsp_o,
  output logic [`GAT_WH_ADDR_W-1:0]          watch0_o,
  output logic [`GAT_WH_ADDR_W-1:0]          watch1_o,
  output logic                               clear_o,
  output logic                               cap_pop_o
);

  logic [`GAT_WH_ADDR_W-1:0]   watch0_q;
  logic [`GAT_WH_ADDR_W-1:0]   watch1_q;
  logic                        bvalid_q;
  logic [1:0]                  bresp_q;
  logic                        rvalid_q;
  logic [1:0]                  rresp_q;
  logic [`GAT_AXIL_DATA_W-1:0] rdata_q;

  logic                        aw_hs;
  logic                        ar_hs;
  logic                        full_strb;
  logic                        wr_watch0;
  logic                        wr_watch1;
  logic                        wr_ctrl;
  logic [1:0]                  wr_resp;
  logic [`GAT_AXIL_DATA_W-1:0] rd_data;
  logic [1:0]                  rd_resp;
  logic                        rd_pop;

  // one transaction of each kind at a time. a pending response blocks the next.
  assign aw_hs     = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign ar_hs     = axil_req_i.arvalid && !rvalid_q;
  assign full_strb = &axil_req_i.wstrb;

  always_comb begin
    wr_watch0 = 1'b0;
    wr_watch1 = 1'b0;
    wr_ctrl   = 1'b0;
    wr_resp   = `GAT_AXI_RESP_OKAY;
    case (axil_req_i.awaddr)
      `REG_WATCH0: wr_watch0 = 1'b1;
      `REG_WATCH1: wr_watch1 = 1'b1;
      `REG_CTRL:   wr_ctrl   = 1'b1;
      // read-only and unmapped offsets alike.
      default:     wr_resp   = `GAT_AXI_RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = `GAT_AXI_RESP_OKAY;
    rd_pop  = 1'b0;
    case (axil_req_i.araddr)
      `REG_ID:         rd_data = `GAT_DBG_ID;
      `REG_STATUS:     rd_data = 32'(sticky_i);
      `REG_SM_COUNT:   rd_data = sm_count_i;
      `REG_NUM_SPARSE: rd_data = 32'(`GAT_H_NUM_SPARSE);
      `REG_WATCH0:     rd_data = 32'(watch0_q);
      `REG_WATCH1:     rd_data = 32'(watch1_q);
      `REG_CTRL:       rd_data = '0;
      `REG_CAP_LEVEL:  rd_data = 32'(cap_level_i);
      `REG_CAP_DATA: begin
        if (cap_empty_i) begin
          rd_resp = `GAT_AXI_RESP_SLVERR;
        end else begin
          rd_data = cap_data_i;
          rd_pop  = 1'b1;
        end
      end
      default:         rd_resp = `GAT_AXI_RESP_SLVERR;
    endcase
  end

  // both pulses act at the accept edge itself.
  assign clear_o   = aw_hs && wr_ctrl && full_strb && axil_req_i.wdata[0];
  assign cap_pop_o = ar_hs && rd_pop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      watch0_q <= '0;
      watch1_q <= '0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (aw_hs && full_strb && wr_watch0) begin
        watch0_q <= axil_req_i.wdata[`GAT_WH_ADDR_W-1:0];
      end
      if (aw_hs && full_strb && wr_watch1) begin
        watch1_q <= axil_req_i.wdata[`GAT_WH_ADDR_W-1:0];
      end
      if (aw_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      bresp_q <= wr_resp;
    end
    if (ar_hs) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp_o.awready = !bvalid_q;
    axil_rsp_o.wready  = !bvalid_q;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.arready = !rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
    axil_rsp_o.rvalid  = rvalid_q;
  end

  assign watch0_o = watch0_q;
  assign watch1_o = watch1_q;

endmodule

`default_nettype wire

//--- capture_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "gat_dbg_defines.svh"

module capture_fifo #(
  parameter type payload_t = gat_dbg_pkg::capture_rec_t
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         push_i,
  input  wire payload_t                     push_data_i,
  input  wire logic                         pop_i,
  output payload_t                          pop_data_o,
  output logic                              full_o,
  output logic                              empty_o,
  output logic [`GAT_CAP_LEVEL_W-1:0]       level_o
);

  localparam int DEPTH = `GAT_CAP_DEPTH;
  localparam int PTR_W = `GAT_CAP_PTR_W;
  localparam int LVL_W = `GAT_CAP_LEVEL_W;

  payload_t             mem_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [LVL_W-1:0]     level_q;

  logic do_push;
  logic do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (level_q == LVL_W'(DEPTH));
  assign empty_o = (level_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // push and pop together leave the level where it is.
      if (do_push && !do_pop) begin
        level_q <= level_q + 1'b1;
      end else if (do_pop && !do_push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  // head entry is visible without a pop. its value is stale when empty.
  assign pop_data_o = mem_q[rd_ptr_q];
  assign level_o    = level_q;

endmodule

`default_nettype wire

//--- stage_event_monitor.sv
`timescale 1ns/100ps
`default_nettype none

`include "gat_dbg_defines.svh"

module stage_event_monitor (
  input  wire logic                                        clk,
  input  wire logic                                        rst_n,
  input  wire gat_dbg_pkg::stage_bus_t                     stages_i,
  input  wire logic [`GAT_WH_ADDR_W-1:0]                   wh_addr_i,
  input  wire logic [`GAT_SPPE_LANES-1:0][`GAT_SPPE_W-1:0] sppe_i,
  input  wire gat_dbg_pkg::feat_wr_t                       feat_wr_i,
  input  wire logic [`GAT_WH_ADDR_W-1:0]                   watch0_i,
  input  wire logic [`GAT_WH_ADDR_W-1:0]                   watch1_i,
  input  wire logic                                        clear_i,
  input  wire logic                                        cap_full_i,
  output gat_dbg_pkg::sticky_t                             sticky_o,
  output logic [31:0]                                      sm_count_o,
  output gat_dbg_pkg::capture_rec_t                        cap_rec_o,
  output logic                                             cap_push_o
);

  gat_dbg_pkg::sticky_t       sticky_q;
  gat_dbg_pkg::sticky_t       sticky_d;
  logic [31:0]                sm_count_q;
  logic [`GAT_CAP_SEQ_W-1:0]  seq_q;

  logic hit0;
  logic hit1;
  logic match;
  logic feat_over;

  assign hit0  = (wh_addr_i == watch0_i);
  assign hit1  = (wh_addr_i == watch1_i);
  assign match = stages_i.spmm.rdy && (hit0 || hit1);

  assign feat_over = feat_wr_i.ena &&
                     (feat_wr_i.addr >= `GAT_FEAT_ADDR_W'(`GAT_FEAT_ADDR_LIMIT));

  // the flags only ever gain bits until a clear.
  always_comb begin
    sticky_d                 = sticky_q;
    sticky_d.hs_seen         = sticky_q.hs_seen | stages_i;
    sticky_d.feat_wr_seen    = sticky_q.feat_wr_seen | feat_wr_i.ena;
    sticky_d.feat_over_limit = sticky_q.feat_over_limit | feat_over;
    sticky_d.cap_overflow    = sticky_q.cap_overflow | (match && cap_full_i);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sticky_q <= '0;
    end else if (clear_i) begin
      sticky_q <= '0;
    end else begin
      sticky_q <= sticky_d;
    end
  end

  // softmax valid cycles wrap at 32 bits.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_q <= '0;
    end else if (clear_i) begin
      sm_count_q <= '0;
    end else if (stages_i.sm.vld) begin
      sm_count_q <= sm_count_q + 32'd1;
    end
  end

  // seq counts every match, so a dropped record leaves a gap the host can see.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_q <= '0;
    end else if (clear_i) begin
      seq_q <= '0;
    end else if (match) begin
      seq_q <= seq_q + 1'b1;
    end
  end

  // the record is formed in the match cycle and the FIFO registers it at
  // the same edge. watch0 wins when both registers hold the same address.
  always_comb begin
    cap_rec_o.watch_hit = !hit0;
    cap_rec_o.addr      = wh_addr_i;
    cap_rec_o.lane      = sppe_i[`GAT_SPPE_WATCH_LANE];
    cap_rec_o.seq       = seq_q;
  end

  assign cap_push_o = match && !cap_full_i;

  assign sticky_o   = sticky_q;
  assign sm_count_o = sm_count_q;

endmodule

`default_nettype wire

//--- gat_dbg_pkg.sv
`default_nettype none

`include "gat_dbg_defines.svh"

package gat_dbg_pkg;

  // valid/ready pair of one compute stage.
  typedef struct packed {
    logic vld;
    logic rdy;
  } stage_hs_t;

  typedef struct packed {
    stage_hs_t spmm;
    stage_hs_t dmvm;
    stage_hs_t sm;
    stage_hs_t aggr;
  } stage_bus_t;

  // layout matches the STATUS register with cap_overflow in bit 0.
  typedef struct packed {
    stage_bus_t hs_seen;
    logic       feat_wr_seen;
    logic       feat_over_limit;
    logic       cap_overflow;
  } sticky_t;

  typedef struct packed {
    logic                          ena;
    logic [`GAT_FEAT_ADDR_W-1:0]   addr;
  } feat_wr_t;

  // one 32-bit word that CAP_DATA returns as is.
  typedef struct packed {
    logic                          watch_hit;
    logic [`GAT_WH_ADDR_W-1:0]     addr;
    logic [`GAT_SPPE_W-1:0]        lane;
    logic [`GAT_CAP_SEQ_W-1:0]     seq;
  } capture_rec_t;

  typedef struct packed {
    logic [`GAT_AXIL_ADDR_W-1:0]   awaddr;
    logic                          awvalid;
    logic [`GAT_AXIL_DATA_W-1:0]   wdata;
    logic [`GAT_AXIL_DATA_W/8-1:0] wstrb;
    logic                          wvalid;
    logic                          bready;
    logic [`GAT_AXIL_ADDR_W-1:0]   araddr;
    logic                          arvalid;
    logic                          rready;
  } axil_req_t;

  typedef struct packed {
    logic                          awready;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          arready;
    logic [`GAT_AXIL_DATA_W-1:0]   rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- gat_dbg_defines.svh
`ifndef GAT_DBG_DEFINES_SVH
`define GAT_DBG_DEFINES_SVH

// accelerator configuration as seen by the debug monitor.
`define GAT_H_NUM_SPARSE     12
`define GAT_SPPE_LANES       16
`define GAT_SPPE_W           12
`define GAT_SPPE_WATCH_LANE  2
`define GAT_WH_ADDR_W        14
`define GAT_FEAT_ADDR_W      16
`define GAT_FEAT_ADDR_LIMIT  43328

// capture FIFO sizing.
`define GAT_CAP_DEPTH        8
`define GAT_CAP_PTR_W        3
`define GAT_CAP_LEVEL_W      4
`define GAT_CAP_SEQ_W        5

`define GAT_DBG_ID           32'h00D7F244

// AXI4-Lite bus.
`define GAT_AXIL_ADDR_W      8
`define GAT_AXIL_DATA_W      32
`define GAT_AXI_RESP_OKAY    2'b00
`define GAT_AXI_RESP_SLVERR  2'b10

// register byte offsets.
`define REG_ID               8'h00
`define REG_STATUS           8'h04
`define REG_SM_COUNT         8'h08
`define REG_NUM_SPARSE       8'h0C
`define REG_WATCH0           8'h10
`define REG_WATCH1           8'h14
`define REG_CTRL             8'h18
`define REG_CAP_LEVEL        8'h1C
`define REG_CAP_DATA         8'h20

`endif
